// ==== src/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // geometry
    localparam int WAYS        = 2;
    localparam int SETS        = 8;
    localparam int BLOCK_WORDS = 4;
    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;

    localparam int OFFSET_W = $clog2(BLOCK_WORDS) + 2;
    localparam int INDEX_W  = $clog2(SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAY_W    = $clog2(WAYS);
    localparam int BLOCK_W  = BLOCK_WORDS * WORD_W;

    typedef enum logic [1:0] {
        ST_INVALID = 2'd0,
        ST_CLEAN   = 2'd1,
        ST_DIRTY   = 2'd2
    } line_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                we;
        logic [WORD_W/8-1:0] be;
        logic [WORD_W-1:0]   wdata;
    } core_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] rdata;
    } core_rsp_t;

    typedef enum logic {
        OP_LOAD       = 1'b0,
        OP_WRITE_BACK = 1'b1
    } bus_op_e;

    typedef logic [BLOCK_WORDS-1:0][WORD_W-1:0] block_t;

    typedef struct packed {
        bus_op_e           op;
        logic [ADDR_W-1:0] addr;
        block_t            data;
    } bus_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic             hit;
        line_state_e      state;
        logic [TAG_W-1:0] tag;
        block_t           block;
    } way_probe_t;

    typedef struct packed {
        logic [WAYS-1:0] sel;
        logic            refill;
        line_state_e     state;
        block_t          block;
    } way_write_t;

    // byte-enabled overlay of a new word onto an old one
    function automatic logic [WORD_W-1:0] merge_word(
        input logic [WORD_W-1:0]   old_w,
        input logic [WORD_W-1:0]   new_w,
        input logic [WORD_W/8-1:0] be
    );
        logic [WORD_W-1:0] res;
        res = old_w;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== src/cache_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_array import cache_pkg::*; #(
    parameter type entry_t = tag_entry_t,
    parameter int  DEPTH   = SETS,
    localparam int ENTRY_W = $bits(entry_t),
    localparam int LANES   = (ENTRY_W + WORD_W - 1) / WORD_W
) (
    input  logic               clk_i,
    input  logic               rd_en_i,
    input  logic               wr_en_i,
    input  logic [INDEX_W-1:0] addr_i,
    input  logic [LANES-1:0]   lane_en_i,
    input  entry_t             wdata_i,
    output entry_t             rdata_o
);

    logic [ENTRY_W-1:0] mem_q [DEPTH];
    logic [ENTRY_W-1:0] wbits;

    assign wbits = wdata_i;

    // lane b/WORD_W gates each bit, last lane may be narrow
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < ENTRY_W; b++) begin
                if (lane_en_i[b / WORD_W]) begin
                    mem_q[addr_i][b] <= wbits[b];
                end
            end
        end
        if (rd_en_i) begin
            rdata_o <= entry_t'(mem_q[addr_i]);
        end
    end

endmodule

`default_nettype wire

// ==== src/cache_way.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_way import cache_pkg::*; #(
    parameter int WAY_ID = 0
) (
    input  logic               clk_i,
    input  logic               nreset_i,
    input  logic [INDEX_W-1:0] index_i,
    input  logic               rd_en_i,
    input  core_req_t          req_i,
    input  way_write_t         wr_i,
    output way_probe_t         probe_o
);

    line_state_e          state_q [SETS];
    line_state_e          state_rd_q;
    tag_entry_t           tag_rd;
    tag_entry_t           req_tag;
    block_t               blk_rd;
    block_t               blk_wr;
    logic                 wr_sel;
    logic                 refill;
    logic [BLOCK_WORDS-1:0] lane_en;
    logic [OFFSET_W-3:0]  woff;
    logic [WORD_W-1:0]    hit_word;

    assign woff        = req_i.addr[OFFSET_W-1:2];
    assign req_tag.tag = req_i.addr[ADDR_W-1 -: TAG_W];
    assign wr_sel      = wr_i.sel[WAY_ID];
    assign refill      = wr_sel & wr_i.refill;

    // write hit touches one lane only, refill the whole block
    assign hit_word = merge_word(blk_rd[woff], req_i.wdata, req_i.be);
    assign blk_wr   = refill ? wr_i.block : {BLOCK_WORDS{hit_word}};
    assign lane_en  = refill ? '1 : (BLOCK_WORDS'(1) << woff);

    cache_array #(
        .entry_t (tag_entry_t)
    ) tag_array_i (
        .clk_i,
        .rd_en_i,
        .wr_en_i   (refill),
        .addr_i    (index_i),
        .lane_en_i (1'b1),
        .wdata_i   (req_tag),
        .rdata_o   (tag_rd)
    );

    cache_array #(
        .entry_t (block_t)
    ) data_array_i (
        .clk_i,
        .rd_en_i,
        .wr_en_i   (wr_sel),
        .addr_i    (index_i),
        .lane_en_i (lane_en),
        .wdata_i   (blk_wr),
        .rdata_o   (blk_rd)
    );

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            for (int s = 0; s < SETS; s++) begin
                state_q[s] <= ST_INVALID;
            end
            state_rd_q <= ST_INVALID;
        end else begin
            if (wr_sel) begin
                state_q[index_i] <= wr_i.state;
            end
            if (rd_en_i) begin
                state_rd_q <= state_q[index_i];
            end
        end
    end

    assign probe_o.hit   = (state_rd_q != ST_INVALID) && (tag_rd.tag == req_tag.tag);
    assign probe_o.state = state_rd_q;
    assign probe_o.tag   = tag_rd.tag;
    assign probe_o.block = blk_rd;

    // refill goes to a missing way, a plain write only to the hitting one
    a_write_kind: assert property (@(posedge clk_i) disable iff (nreset_i)
        wr_sel |-> (wr_i.refill ? !probe_o.hit : (probe_o.hit && req_i.we)));

endmodule

`default_nettype wire

// ==== src/cache_req_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_req_stage import cache_pkg::*; (
    input  logic               clk_i,
    input  logic               nreset_i,
    input  logic               cc_valid_i,
    input  core_req_t          cc_req_i,
    output logic               cc_ready_o,
    input  logic               retire_i,
    input  logic               reread_i,
    output core_req_t          req_o,
    output logic               busy_o,
    output logic [INDEX_W-1:0] index_o,
    output logic               rd_en_o
);

    logic      busy_q;
    logic      accept;
    core_req_t req_q;

    assign cc_ready_o = ~busy_q;
    assign accept     = cc_valid_i & ~busy_q;

    // incoming index on accept so the arrays read at the same edge
    assign index_o = accept ? cc_req_i.addr[OFFSET_W +: INDEX_W]
                            : req_q.addr[OFFSET_W +: INDEX_W];
    assign rd_en_o = accept | reread_i;

    assign req_o  = req_q;
    assign busy_o = busy_q;

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (retire_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= cc_req_i;
        end
    end

    // a contiguous run has at most two edges
    a_be_contiguous: assert property (@(posedge clk_i) disable iff (nreset_i)
        accept && cc_req_i.we |->
            $countones({1'b0, cc_req_i.be} ^ {cc_req_i.be, 1'b0}) <= 2);

endmodule

`default_nettype wire

// ==== src/cache_miss_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_miss_ctrl import cache_pkg::*; (
    input  logic                   clk_i,
    input  logic                   nreset_i,
    input  logic                   busy_i,
    input  core_req_t              req_i,
    input  way_probe_t [WAYS-1:0]  probe_i,
    output way_write_t             wr_o,
    output logic                   retire_o,
    output logic                   reread_o,
    output logic                   cc_valid_o,
    output core_rsp_t              cc_rsp_o,
    output logic                   cb_valid_o,
    input  logic                   cb_yumi_i,
    output bus_req_t               cb_req_o,
    input  logic                   cb_valid_i,
    input  block_t                 cb_rdata_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITEBACK,
        S_LOAD,
        S_REFILL,
        S_FILL,
        S_REREAD
    } ctrl_state_e;

    ctrl_state_e         state_q;
    ctrl_state_e         state_d;
    logic                lookup;
    logic                hit_any;
    logic [WAYS-1:0]     hit_vec;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    victim_c;
    logic [WAY_W-1:0]    victim_q;
    logic [WAY_W-1:0]    way_sel;
    logic [WAY_W-1:0]    mru_q [SETS];
    logic                victim_dirty;
    logic                send_wb;
    logic                taken;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-3:0] woff;
    logic [WORD_W-1:0]   rd_word;
    block_t              fill_d;
    block_t              fill_q;

    assign index  = req_i.addr[OFFSET_W +: INDEX_W];
    assign woff   = req_i.addr[OFFSET_W-1:2];
    // first busy cycle after idle is the lookup
    assign lookup = (state_q == S_IDLE) && busy_i;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = probe_i[w].hit;
            if (probe_i[w].hit) begin
                hit_way = WAY_W'(w);
            end
        end
    end
    assign hit_any = |hit_vec;

    // lowest invalid way, else the one not used last
    always_comb begin
        victim_c = ~mru_q[index];
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (probe_i[w].state == ST_INVALID) begin
                victim_c = WAY_W'(w);
            end
        end
    end

    assign way_sel      = lookup ? victim_c : victim_q;
    assign victim_dirty = probe_i[way_sel].state == ST_DIRTY;
    assign send_wb      = (lookup && !hit_any && victim_dirty) || (state_q == S_WRITEBACK);
    assign cb_valid_o   = (lookup && !hit_any) || (state_q == S_WRITEBACK) || (state_q == S_LOAD);
    assign taken        = cb_valid_o & cb_yumi_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            S_IDLE: begin
                if (lookup && !hit_any) begin
                    if (victim_dirty) begin
                        state_d = taken ? S_LOAD : S_WRITEBACK;
                    end else begin
                        state_d = taken ? S_REFILL : S_LOAD;
                    end
                end
            end
            S_WRITEBACK: if (taken) state_d = S_LOAD;
            S_LOAD:      if (taken) state_d = S_REFILL;
            S_REFILL:    if (cb_valid_i) state_d = S_FILL;
            S_FILL:      state_d = S_REREAD;
            S_REREAD:    state_d = S_IDLE;
            default:     state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_q <= S_IDLE;
            for (int s = 0; s < SETS; s++) begin
                mru_q[s] <= '0;
            end
        end else begin
            state_q <= state_d;
            if (lookup && hit_any) begin
                mru_q[index] <= hit_way;
            end else if (state_q == S_FILL) begin
                mru_q[index] <= victim_q;
            end
        end
    end

    // pending write lands in the fetched block before it is stored
    always_comb begin
        fill_d = cb_rdata_i;
        if (req_i.we) begin
            fill_d[woff] = merge_word(cb_rdata_i[woff], req_i.wdata, req_i.be);
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup) begin
            victim_q <= victim_c;
        end
        if ((state_q == S_REFILL) && cb_valid_i) begin
            fill_q <= fill_d;
        end
    end

    always_comb begin
        cb_req_o.op = send_wb ? OP_WRITE_BACK : OP_LOAD;
        if (send_wb) begin
            cb_req_o.addr = {probe_i[way_sel].tag, index, {OFFSET_W{1'b0}}};
            cb_req_o.data = probe_i[way_sel].block;
        end else begin
            cb_req_o.addr = {req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            cb_req_o.data = '0;
        end
    end

    always_comb begin
        wr_o.sel    = '0;
        wr_o.refill = 1'b0;
        wr_o.state  = ST_DIRTY;
        wr_o.block  = fill_q;
        if (lookup && req_i.we) begin
            wr_o.sel = hit_vec;
        end
        if (state_q == S_FILL) begin
            wr_o.sel    = WAYS'(1) << victim_q;
            wr_o.refill = 1'b1;
            wr_o.state  = req_i.we ? ST_DIRTY : ST_CLEAN;
        end
    end

    assign rd_word        = (state_q == S_FILL) ? fill_q[woff] : probe_i[hit_way].block[woff];
    assign cc_rsp_o.rdata = req_i.we ? '0 : rd_word;
    assign cc_valid_o     = (lookup && hit_any) || (state_q == S_FILL);
    assign retire_o       = (lookup && hit_any) || (state_q == S_REREAD);
    assign reread_o       = state_q == S_REREAD;

    a_one_hit: assert property (@(posedge clk_i) disable iff (nreset_i)
        lookup |-> $onehot0(hit_vec));

    a_refill_expected: assert property (@(posedge clk_i) disable iff (nreset_i)
        cb_valid_i |-> state_q == S_REFILL);

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic      clk_i,
    input  logic      nreset_i,

    // core side
    input  logic      cc_valid_i,
    input  core_req_t cc_req_i,
    output logic      cc_ready_o,
    output logic      cc_valid_o,
    output core_rsp_t cc_rsp_o,

    // bus side
    output logic      cb_valid_o,
    input  logic      cb_yumi_i,
    output bus_req_t  cb_req_o,
    input  logic      cb_valid_i,
    input  block_t    cb_rdata_i
);

    core_req_t             req;
    logic                  busy;
    logic                  retire;
    logic                  reread;
    logic                  rd_en;
    logic [INDEX_W-1:0]    index;
    way_probe_t [WAYS-1:0] probes;
    way_write_t            way_wr;

    cache_req_stage req_stage_i (
        .clk_i,
        .nreset_i,
        .cc_valid_i,
        .cc_req_i,
        .cc_ready_o,
        .retire_i (retire),
        .reread_i (reread),
        .req_o    (req),
        .busy_o   (busy),
        .index_o  (index),
        .rd_en_o  (rd_en)
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_way #(
            .WAY_ID (w)
        ) way_i (
            .clk_i,
            .nreset_i,
            .index_i (index),
            .rd_en_i (rd_en),
            .req_i   (req),
            .wr_i    (way_wr),
            .probe_o (probes[w])
        );
    end

    cache_miss_ctrl miss_ctrl_i (
        .clk_i,
        .nreset_i,
        .busy_i     (busy),
        .req_i      (req),
        .probe_i    (probes),
        .wr_o       (way_wr),
        .retire_o   (retire),
        .reread_o   (reread),
        .cc_valid_o,
        .cc_rsp_o,
        .cb_valid_o,
        .cb_yumi_i,
        .cb_req_o,
        .cb_valid_i,
        .cb_rdata_i
    );

endmodule

`default_nettype wire

// ==== verif/cache_tb_tasks.svh ====
`ifndef CACHE_TB_TASKS_SVH
`define CACHE_TB_TASKS_SVH

task automatic report_mismatch(input string what);
    $display("Fail at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1);
endtask

function automatic logic [ADDR_W-1:0] block_base(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
endfunction

// first touch of a block gives it random contents in memory and shadow
function automatic void ensure_block(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] base;
    block_t            blk;
    base = block_base(addr);
    if (!mem.exists(base)) begin
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            blk[i] = $random(seed);
            shadow[base + ADDR_W'(4 * i)] = blk[i];
        end
        mem[base] = blk;
    end
endfunction

function automatic block_t shadow_block(input logic [ADDR_W-1:0] base);
    block_t blk;
    for (int i = 0; i < BLOCK_WORDS; i++) begin
        blk[i] = shadow[base + ADDR_W'(4 * i)];
    end
    return blk;
endfunction

function automatic logic [WORD_W-1:0] masked_update(
    input logic [WORD_W-1:0] old_w,
    input logic [WORD_W-1:0] new_w,
    input logic [3:0]        be
);
    logic [WORD_W-1:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
endfunction

// one request with cycles counted from the accept edge to the response
task automatic access(
    input  logic [ADDR_W-1:0] req_addr,
    input  logic              req_we,
    input  logic [3:0]        req_be,
    input  logic [WORD_W-1:0] req_wdata,
    output logic [WORD_W-1:0] rdata,
    output int                cycles
);
    @(negedge clk_i);
    while (!cc_ready_o) @(negedge clk_i);
    cc_req_i   = '{addr: req_addr, we: req_we, be: req_be, wdata: req_wdata};
    cc_valid_i = 1'b1;
    @(negedge clk_i);
    cc_valid_i = 1'b0;
    cycles     = 1;
    while (!cc_valid_o) begin
        @(negedge clk_i);
        cycles++;
    end
    rdata = cc_rsp_o.rdata;
endtask

task automatic check_hit(input logic [ADDR_W-1:0] addr, input bit hit, input int cycles);
    if (hit) begin
        assert (cycles == 1 && bus_log.size() == 0)
        else report_mismatch($sformatf("hit on %h took %0d cycles and %0d bus packets",
                                       addr, cycles, bus_log.size()));
    end else begin
        assert (cycles > 1 && bus_log.size() > 0)
        else report_mismatch($sformatf("miss on %h answered without a bus load", addr));
    end
endtask

task automatic read_and_compare(input logic [ADDR_W-1:0] addr, input bit hit);
    logic [WORD_W-1:0] got;
    int                cycles;
    ensure_block(addr);
    bus_log.delete();
    access(addr, 1'b0, 4'b0000, '0, got, cycles);
    assert (got == shadow[addr])
    else report_mismatch($sformatf("read %h returned %h, expected %h",
                                   addr, got, shadow[addr]));
    check_hit(addr, hit, cycles);
endtask

task automatic write_and_track(
    input logic [ADDR_W-1:0] addr,
    input logic [3:0]        be,
    input logic [WORD_W-1:0] data,
    input bit                hit
);
    logic [WORD_W-1:0] got;
    int                cycles;
    ensure_block(addr);
    bus_log.delete();
    access(addr, 1'b1, be, data, got, cycles);
    assert (got == '0)
    else report_mismatch($sformatf("write %h returned data %h instead of zero", addr, got));
    shadow[addr] = masked_update(shadow[addr], data, be);
    check_hit(addr, hit, cycles);
endtask

task automatic expect_packet_count(input int n);
    assert (bus_log.size() == n)
    else report_mismatch($sformatf("saw %0d bus packets, expected %0d", bus_log.size(), n));
endtask

task automatic expect_load(input int idx, input logic [ADDR_W-1:0] base);
    assert (bus_log[idx].op == OP_LOAD && bus_log[idx].addr == base)
    else report_mismatch($sformatf("packet %0d is op %0d addr %h, expected load of %h",
                                   idx, bus_log[idx].op, bus_log[idx].addr, base));
endtask

task automatic expect_write_back(input int idx, input logic [ADDR_W-1:0] base,
                                 input block_t data);
    assert (bus_log[idx].op == OP_WRITE_BACK && bus_log[idx].addr == base)
    else report_mismatch($sformatf("packet %0d is op %0d addr %h, expected write back of %h",
                                   idx, bus_log[idx].op, bus_log[idx].addr, base));
    assert (bus_log[idx].data == data)
    else report_mismatch($sformatf("write back data %h, expected %h", bus_log[idx].data, data));
endtask

task automatic reset_and_first_read();
    logic [ADDR_W-1:0] a;
    a = 32'h1000_0004;
    @(negedge clk_i);
    assert (cc_ready_o === 1'b1 && cc_valid_o === 1'b0 && cb_valid_o === 1'b0)
    else report_mismatch("handshake outputs wrong after reset");
    read_and_compare(a, 1'b0);
    expect_packet_count(1);
    expect_load(0, block_base(a));
    read_and_compare(a, 1'b1);
endtask

task automatic masked_write_hit();
    write_and_track(32'h1000_0004, 4'b0110, 32'hA5A5_5A5A, 1'b1);
    read_and_compare(32'h1000_0004, 1'b1);
endtask

task automatic write_miss_allocate();
    logic [ADDR_W-1:0] b;
    b = 32'h2000_0018;
    write_and_track(b, 4'b1111, 32'hDEAD_BEEF, 1'b0);
    expect_packet_count(1);
    expect_load(0, block_base(b));
    // neighbour still holds the memory value
    read_and_compare(b + 32'd4, 1'b1);
    read_and_compare(b, 1'b1);
endtask

// three tags in set 2 whose victims follow invalid-first then least recent
task automatic evict_by_lru();
    logic [ADDR_W-1:0] t0;
    logic [ADDR_W-1:0] t1;
    logic [ADDR_W-1:0] t2;
    block_t            wb_blk;
    t0 = 32'h3000_0024;
    t1 = t0 + 32'h80;
    t2 = t0 + 32'h100;
    write_and_track(t0, 4'b0011, 32'h1234_5678, 1'b0);
    read_and_compare(t1, 1'b0);
    expect_packet_count(1);
    read_and_compare(t0, 1'b1);
    // t1 is least recent and clean
    read_and_compare(t2, 1'b0);
    expect_packet_count(1);
    expect_load(0, block_base(t2));
    // now the dirty t0 is least recent
    wb_blk = shadow_block(block_base(t0));
    read_and_compare(t1, 1'b0);
    expect_packet_count(2);
    expect_write_back(0, block_base(t0), wb_blk);
    expect_load(1, block_base(t1));
    read_and_compare(t0, 1'b0);
    expect_packet_count(1);
    expect_load(0, block_base(t0));
endtask

task automatic hold_bus_request();
    logic [ADDR_W-1:0] c;
    c            = 32'h4000_0038;
    held_cycles  = 0;
    stall_cycles = 6;
    read_and_compare(c, 1'b0);
    assert (held_cycles == 6)
    else report_mismatch($sformatf("packet held for %0d cycles, expected 6", held_cycles));
    expect_packet_count(1);
    expect_load(0, block_base(c));
endtask

`endif

// ==== verif/cache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_tb import cache_pkg::*; ();

    localparam int CLK_PERIOD    = 10;
    // upper bounds on the directed sequence
    localparam int ACCESSES      = 20;
    localparam int ACCESS_CYCLES = 100;
    localparam int WATCHDOG_NS   = CLK_PERIOD * ACCESSES * ACCESS_CYCLES;

    logic      clk_i;
    logic      nreset_i;
    logic      cc_valid_i;
    core_req_t cc_req_i;
    logic      cc_ready_o;
    logic      cc_valid_o;
    core_rsp_t cc_rsp_o;
    logic      cb_valid_o;
    logic      cb_yumi_i;
    bus_req_t  cb_req_o;
    logic      cb_valid_i;
    block_t    cb_rdata_i;

    // backing memory by block address and expected core view by word address
    block_t            mem [logic [ADDR_W-1:0]];
    logic [WORD_W-1:0] shadow [logic [ADDR_W-1:0]];
    bus_req_t          bus_log [$];
    int                stall_cycles = 0;
    int                held_cycles = 0;
    integer            seed = 38;

    `include "cache_tb_tasks.svh"

    cache_top cache_top_i (
        .clk_i,
        .nreset_i,
        .cc_valid_i,
        .cc_req_i,
        .cc_ready_o,
        .cc_valid_o,
        .cc_rsp_o,
        .cb_valid_o,
        .cb_yumi_i,
        .cb_req_o,
        .cb_valid_i,
        .cb_rdata_i
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // bus slave takes packets unless stalled and answers loads after 1 to 4 cycles
    initial begin : memory_model
        logic [ADDR_W-1:0] load_base;
        bus_req_t          held_req;
        bit                held;
        bit                pending;
        int                delay;
        cb_yumi_i  = 1'b0;
        cb_valid_i = 1'b0;
        cb_rdata_i = '0;
        load_base  = '0;
        held_req   = '0;
        held       = 1'b0;
        pending    = 1'b0;
        delay      = 0;
        forever begin
            @(negedge clk_i);
            cb_valid_i = 1'b0;
            if (pending) begin
                delay--;
                if (delay == 0) begin
                    cb_valid_i = 1'b1;
                    cb_rdata_i = mem[load_base];
                    pending    = 1'b0;
                end
            end
            if (held) begin
                assert (cb_valid_o && cb_req_o == held_req && !cc_ready_o)
                else report_mismatch("bus packet changed or dropped while not taken");
                held_cycles++;
            end
            cb_yumi_i = 1'b0;
            held      = 1'b0;
            if (cb_valid_o === 1'b1) begin
                if (stall_cycles > 0) begin
                    stall_cycles--;
                    held     = 1'b1;
                    held_req = cb_req_o;
                end else begin
                    cb_yumi_i = 1'b1;
                    bus_log.push_back(cb_req_o);
                    if (cb_req_o.op == OP_WRITE_BACK) begin
                        mem[cb_req_o.addr] = cb_req_o.data;
                    end else begin
                        ensure_block(cb_req_o.addr);
                        load_base = cb_req_o.addr;
                        pending   = 1'b1;
                        delay     = 1 + int'($unsigned($random(seed)) % 4);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, a request never completed", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin : main
        nreset_i   = 1'b1;
        cc_valid_i = 1'b0;
        cc_req_i   = '0;
        repeat (4) @(negedge clk_i);
        nreset_i = 1'b0;

        reset_and_first_read();
        masked_write_hit();
        write_miss_allocate();
        evict_by_lru();
        hold_bus_request();

        repeat (2) @(negedge clk_i);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verif
src/cache_pkg.sv
src/cache_array.sv
src/cache_way.sv
src/cache_req_stage.sv
src/cache_miss_ctrl.sv
src/cache_top.sv
verif/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f \
    --top-module cache_tb -o cache_tb_sim &&
./obj_dir/cache_tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }
